// ==== common/tx_types_pkg.sv ====
`default_nettype none

package tx_types_pkg;

   localparam int SEQ_W = 12;

   // same bit layout as the deframer data word, odd in bit 175
   typedef struct packed {
      logic             odd;
      logic             send_at;
      logic             eob;
      logic             eop;
      logic [SEQ_W-1:0] seqnum;
      logic [31:0]      sid;
      logic [63:0]      send_time;
      logic [31:0]      sample0;
      logic [31:0]      sample1;
   } tx_word_t;

   typedef enum logic [2:0] {
      EV_EOB_ACK,
      EV_UNDERRUN,
      EV_SEQ_ERROR,
      EV_TIME_ERROR,
      EV_SEQ_ERROR_MIDBURST
   } tx_event_e;

   typedef struct packed {
      tx_event_e        kind;
      logic [SEQ_W-1:0] seqnum;
      logic [SEQ_W-1:0] expected;   // only meaningful for seq errors
      logic [31:0]      sid;
   } tx_report_t;

endpackage

`default_nettype wire

// ==== common/tx_cfg_pkg.sv ====
`default_nettype none

package tx_cfg_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef enum logic [1:0] {
      POL_NEXT_PACKET = 2'd0,
      POL_NEXT_BURST  = 2'd1
   } tx_policy_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SAMP0,
      ST_SAMP1,
      ST_ERROR
   } tx_state_e;

endpackage

`default_nettype wire

// ==== common/tx_status_if.sv ====
`default_nettype none

interface tx_status_if;
   import tx_types_pkg::*;

   logic        pending;
   tx_report_t  report;   // stable while pending
   logic [31:0] sid;
   logic        accept;

   modport reporter (output pending, output report, output sid, input accept);

   modport collector (input pending, input report, input sid, output accept);

endinterface

`default_nettype wire

// ==== tx_channel/tx_sample_fifo.sv ====
`default_nettype none

module tx_sample_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   push,
   input  tx_types_pkg::tx_word_t push_word,
   input  logic                   pop,
   output logic                   head_valid,
   output tx_types_pkg::tx_word_t head,
   output logic                   credit
);
   import tx_types_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   tx_word_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign head_valid = count != '0;
   assign head       = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         count  <= count + CNT_W'(push) - CNT_W'(pop);
         credit <= pop;   // one credit back per word
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= push_word;
   end

endmodule

`default_nettype wire

// ==== tx_channel/tx_channel.sv ====
`default_nettype none

module tx_channel #(
   parameter int                                  FIFO_DEPTH = 4,
   parameter logic [tx_cfg_pkg::SET_ADDR_W-1:0]   BASE       = '0
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                set_stb,
   input  logic [tx_cfg_pkg::SET_ADDR_W-1:0]   set_addr,
   input  logic [tx_cfg_pkg::SET_DATA_W-1:0]   set_data,
   input  logic [63:0]                         vita_time,
   input  logic                                ch_valid,
   input  tx_types_pkg::tx_word_t              ch_word,
   output logic                                ch_credit,
   output logic [31:0]                         sample,
   output logic                                run,
   input  logic                                strobe,
   tx_status_if.reporter                       status
);
   import tx_types_pkg::*;
   import tx_cfg_pkg::*;

   tx_state_e        state, state_d;
   tx_policy_e       policy;
   tx_word_t         head;
   tx_event_e        rep_kind;
   tx_report_t       rep_q;
   logic [SEQ_W-1:0] expected_q;
   logic [31:0]      last_sid;
   logic             head_valid, pop, rep_fire, rep_pend, clr_latch;
   logic             now, late, burst_start, seq_ok, can_rep, last_sample, time_to_clear;

   tx_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (ch_valid),
      .push_word  (ch_word),
      .pop        (pop),
      .head_valid (head_valid),
      .head       (head),
      .credit     (ch_credit)
   );

   assign now         = vita_time == head.send_time;
   assign late        = vita_time > head.send_time;
   assign burst_start = ~head.send_at | now;
   assign seq_ok      = head.seqnum == expected_q;
   assign can_rep     = ~rep_pend;   // hold still while a report waits

   assign run    = (state == ST_SAMP0) || (state == ST_SAMP1);
   assign sample = (state == ST_SAMP0) ? head.sample0 : head.sample1;

   always_comb begin
      state_d  = state;
      rep_fire = 1'b0;
      rep_kind = EV_EOB_ACK;
      pop      = 1'b0;
      case (state)
         ST_IDLE: begin
            if (head_valid && burst_start) begin
               if (seq_ok) begin
                  state_d = ST_SAMP0;
               end else if (can_rep) begin
                  state_d  = ST_ERROR;
                  rep_fire = 1'b1;
                  rep_kind = EV_SEQ_ERROR;
               end
            end else if (head_valid && late && can_rep) begin
               state_d  = ST_ERROR;
               rep_fire = 1'b1;
               rep_kind = EV_TIME_ERROR;
            end
         end
         ST_SAMP0: begin
            if (strobe) begin
               if (!head_valid) begin
                  if (can_rep) begin
                     state_d  = ST_ERROR;
                     rep_fire = 1'b1;
                     rep_kind = EV_UNDERRUN;
                  end
               end else if (!seq_ok) begin
                  if (can_rep) begin
                     state_d  = ST_ERROR;
                     rep_fire = 1'b1;
                     rep_kind = EV_SEQ_ERROR_MIDBURST;
                  end
               end else if (head.eop && head.odd) begin
                  if (!head.eob) begin
                     pop = 1'b1;   // odd packet ends after one sample
                  end else if (can_rep) begin
                     pop      = 1'b1;
                     state_d  = ST_IDLE;
                     rep_fire = 1'b1;
                  end
               end else begin
                  state_d = ST_SAMP1;
               end
            end
         end
         ST_SAMP1: begin
            if (strobe) begin
               if (!(head.eop && head.eob)) begin
                  pop     = 1'b1;
                  state_d = ST_SAMP0;
               end else if (can_rep) begin
                  pop      = 1'b1;
                  state_d  = ST_IDLE;
                  rep_fire = 1'b1;
               end
            end
         end
         default: begin
            pop = head_valid;   // drain without strobes
            if (head_valid && head.eop && (policy != POL_NEXT_BURST || head.eob)) begin
               state_d = ST_IDLE;
            end
         end
      endcase
   end

   assign last_sample   = pop & head.eop;
   assign time_to_clear = clr_latch & ((last_sample & head.eob) | (state == ST_ERROR) |
                                       ((state == ST_IDLE) & ~(head_valid & burst_start)));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         policy     <= POL_NEXT_PACKET;
         clr_latch  <= 1'b0;
         expected_q <= '0;
         rep_pend   <= 1'b0;
      end else begin
         state <= state_d;
         if (set_stb && set_addr == BASE) begin
            policy    <= tx_policy_e'(set_data[1:0]);
            clr_latch <= 1'b1;
         end
         if (time_to_clear) begin
            expected_q <= '0;
            clr_latch  <= 1'b0;
         end else if (last_sample) begin
            expected_q <= head.seqnum + 1'b1;
         end
         if (rep_fire) rep_pend <= 1'b1;
         else if (status.accept) rep_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) last_sid <= head.sid;
      if (rep_fire) begin
         rep_q.kind     <= rep_kind;
         rep_q.expected <= expected_q;
         // underrun has no head so tag it with the running packet
         rep_q.seqnum   <= head_valid ? head.seqnum : expected_q;
         rep_q.sid      <= head_valid ? head.sid : last_sid;
      end
   end

   assign status.pending = rep_pend;
   assign status.report  = rep_q;
   assign status.sid     = rep_q.sid;

endmodule

`default_nettype wire

// ==== source/tx_distributor.sv ====
`default_nettype none

module tx_distributor #(
   parameter int  NUM_CH     = 2,
   parameter int  FIFO_DEPTH = 4,
   localparam int CH_W       = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  tx_types_pkg::tx_word_t in_word,
   input  logic [CH_W-1:0]        in_chan,
   output logic                   in_ready,
   output logic [NUM_CH-1:0]      ch_valid,
   output tx_types_pkg::tx_word_t ch_word,
   input  logic [NUM_CH-1:0]      ch_credit
);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [CNT_W-1:0]  credit_q [NUM_CH];
   logic [NUM_CH-1:0] send;

   assign in_ready = (int'(in_chan) < NUM_CH) && (credit_q[in_chan] != '0);

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         send[i] = in_valid && in_ready && (int'(in_chan) == i);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ch_valid <= '0;
         for (int i = 0; i < NUM_CH; i++) begin
            credit_q[i] <= CNT_W'(FIFO_DEPTH);   // buffers start empty
         end
      end else begin
         ch_valid <= send;
         for (int i = 0; i < NUM_CH; i++) begin
            credit_q[i] <= credit_q[i] - CNT_W'(send[i]) + CNT_W'(ch_credit[i]);
         end
      end
   end

   // word goes out to every channel, ch_valid picks the one
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         ch_word <= in_word;
      end
   end

endmodule

`default_nettype wire

// ==== source/tx_status_arbiter.sv ====
`default_nettype none

module tx_status_arbiter #(
   parameter int  NUM_CH = 2,
   localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
   input  logic                     clk,
   input  logic                     rst_n,
   tx_status_if.collector           status [NUM_CH],
   output logic                     status_valid,
   output logic [CH_W-1:0]          status_chan,
   output tx_types_pkg::tx_report_t status_report,
   input  logic                     status_ready
);
   import tx_types_pkg::*;

   logic [NUM_CH-1:0] pend, accept;
   tx_report_t        rep [NUM_CH];
   logic [CH_W-1:0]   last_q, grant;
   logic              found;

   for (genvar i = 0; i < NUM_CH; i++) begin : g_flat
      assign pend[i]          = status[i].pending;
      assign rep[i]           = {status[i].report.kind, status[i].report.seqnum,
                                 status[i].report.expected, status[i].sid};
      assign status[i].accept = accept[i];
   end

   // search starts just after the last granted channel
   always_comb begin
      int idx;
      found = 1'b0;
      grant = last_q;
      for (int k = 1; k <= NUM_CH; k++) begin
         idx = (int'(last_q) + k) % NUM_CH;
         if (!found && pend[idx]) begin
            found = 1'b1;
            grant = CH_W'(idx);
         end
      end
      for (int i = 0; i < NUM_CH; i++) begin
         accept[i] = !status_valid && found && (int'(grant) == i);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_valid <= 1'b0;
         last_q       <= CH_W'(NUM_CH - 1);   // channel 0 goes first
      end else if (|accept) begin
         status_valid <= 1'b1;
         last_q       <= grant;
      end else if (status_ready) begin
         status_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (|accept) begin
         status_chan   <= grant;
         status_report <= rep[grant];
      end
   end

endmodule

`default_nettype wire

// ==== source/tx_subsystem.sv ====
`default_nettype none

module tx_subsystem #(
   parameter int                                NUM_CH     = 2,
   parameter int                                FIFO_DEPTH = 4,
   parameter logic [tx_cfg_pkg::SET_ADDR_W-1:0] SET_BASE   = 8'h10,
   localparam int                               CH_W       = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                in_valid,
   input  tx_types_pkg::tx_word_t              in_word,
   input  logic [CH_W-1:0]                     in_chan,
   output logic                                in_ready,
   output logic                                status_valid,
   output logic [CH_W-1:0]                     status_chan,
   output tx_types_pkg::tx_report_t            status_report,
   input  logic                                status_ready,
   input  logic                                set_stb,
   input  logic [tx_cfg_pkg::SET_ADDR_W-1:0]   set_addr,
   input  logic [tx_cfg_pkg::SET_DATA_W-1:0]   set_data,
   input  logic [63:0]                         vita_time,
   output logic [NUM_CH-1:0][31:0]             sample,
   output logic [NUM_CH-1:0]                   run,
   input  logic [NUM_CH-1:0]                   strobe
);
   import tx_types_pkg::*;
   import tx_cfg_pkg::*;

   logic [NUM_CH-1:0] ch_valid;
   logic [NUM_CH-1:0] ch_credit;
   tx_word_t          ch_word;

   tx_status_if st_if [NUM_CH] ();

   tx_distributor #(.NUM_CH(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) u_dist (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_word   (in_word),
      .in_chan   (in_chan),
      .in_ready  (in_ready),
      .ch_valid  (ch_valid),
      .ch_word   (ch_word),
      .ch_credit (ch_credit)
   );

   for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
      tx_channel #(
         .FIFO_DEPTH (FIFO_DEPTH),
         .BASE       (SET_BASE + SET_ADDR_W'(g))   // one settings address per channel
      ) u_ch (
         .clk       (clk),
         .rst_n     (rst_n),
         .set_stb   (set_stb),
         .set_addr  (set_addr),
         .set_data  (set_data),
         .vita_time (vita_time),
         .ch_valid  (ch_valid[g]),
         .ch_word   (ch_word),
         .ch_credit (ch_credit[g]),
         .sample    (sample[g]),
         .run       (run[g]),
         .strobe    (strobe[g]),
         .status    (st_if[g])
      );
   end

   tx_status_arbiter #(.NUM_CH(NUM_CH)) u_arb (
      .clk           (clk),
      .rst_n         (rst_n),
      .status        (st_if),
      .status_valid  (status_valid),
      .status_chan   (status_chan),
      .status_report (status_report),
      .status_ready  (status_ready)
   );

endmodule

`default_nettype wire

// ==== verif/tb_tx_subsystem.sv ====
`default_nettype none

module tb_tx_subsystem;
   import tx_types_pkg::*;
   import tx_cfg_pkg::*;

   localparam int TIMEOUT = 3000;

   logic             clk = 1'b0;
   logic             rst_n = 1'b0;
   logic             in_valid = 1'b0;
   tx_word_t         in_word = '0;
   logic [0:0]       in_chan = '0;
   logic             in_ready;
   logic             status_valid;
   logic [0:0]       status_chan;
   tx_report_t       status_report;
   logic             status_ready = 1'b1;
   logic             set_stb = 1'b0;
   logic [7:0]       set_addr = '0;
   logic [31:0]      set_data = '0;
   logic [63:0]      vita_time = 64'd100;
   logic [1:0][31:0] sample;
   logic [1:0]       run;
   logic [1:0]       strobe = '0;

   integer      seed;
   int          stb_cnt = 0;
   bit          saw_full = 1'b0;
   logic [32:0] samp_q [2][$];   // bit 32 marks a strobe that consumes nothing
   tx_report_t  rep_q [$];
   int          chan_q [$];
   logic [11:0] m_exp [2];
   logic [31:0] m_sid [2];
   logic [32:0] ent;
   tx_report_t  rexp;
   tx_word_t    w;
   logic [63:0] t_start;
   int          t;

   tx_subsystem #(.NUM_CH(2), .FIFO_DEPTH(4), .SET_BASE(8'h10)) UUT (
      .clk (clk), .rst_n (rst_n),
      .in_valid (in_valid), .in_word (in_word), .in_chan (in_chan), .in_ready (in_ready),
      .status_valid (status_valid), .status_chan (status_chan),
      .status_report (status_report), .status_ready (status_ready),
      .set_stb (set_stb), .set_addr (set_addr), .set_data (set_data),
      .vita_time (vita_time), .sample (sample), .run (run), .strobe (strobe)
   );

   always #4 clk = ~clk;

   always @(negedge clk) begin
      stb_cnt   = (stb_cnt == 3) ? 0 : stb_cnt + 1;
      strobe    = {2{stb_cnt == 0}};   // one strobe every 4 cycles
      vita_time = vita_time + 1;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_sample(input int ch, input logic [31:0] e, input logic [31:0] a);
      if (e !== a) begin
         $display("[ERROR] sample[%0d] expected %h actual %h", ch, e, a);
         abort_run("sample mismatch");
      end
   endtask

   task automatic check_report(input tx_report_t e, input tx_report_t a);
      if (e !== a) begin
         $display("[ERROR] status_report expected %h actual %h", e, a);
         abort_run("report mismatch");
      end
   endtask

   task automatic check_chan(input logic [0:0] e, input logic [0:0] a);
      if (e !== a) begin
         $display("[ERROR] status_chan expected %h actual %h", e, a);
         abort_run("channel tag mismatch");
      end
   endtask

   // values settle in the low phase so look half way through it
   always begin
      @(negedge clk);
      #2;
      for (int c = 0; c < 2; c++) begin
         if (strobe[c] && run[c]) begin
            if (samp_q[c].size() == 0) abort_run("strobe consumed a sample nobody expected");
            ent = samp_q[c].pop_front();
            if (!ent[32]) check_sample(c, ent[31:0], sample[c]);
         end
      end
      if (status_valid && status_ready) begin
         if (rep_q.size() == 0) abort_run("status report arrived that was not expected");
         rexp = rep_q.pop_front();
         check_chan(1'(chan_q.pop_front()), status_chan);
         check_report(rexp, status_report);
      end
   end

   function automatic tx_word_t make_word(input int ch, input logic [11:0] seq, input bit eob,
                                          input bit odd, input bit send_at,
                                          input logic [63:0] tm);
      tx_word_t x;
      x.sample0   = $random(seed);
      x.sample1   = $random(seed);
      x.send_time = tm;
      x.sid       = 32'hc0de0000 + ch;
      x.seqnum    = seq;
      x.eop       = 1'b1;   // one word per packet
      x.eob       = eob;
      x.send_at   = send_at;
      x.odd       = odd;
      return x;
   endfunction

   function automatic tx_report_t model_event(input int ch, input tx_event_e kind,
                                              input tx_word_t x);
      tx_report_t r;
      r.kind     = kind;
      r.expected = m_exp[ch];
      r.seqnum   = (kind == EV_UNDERRUN) ? m_exp[ch] : x.seqnum;
      r.sid      = (kind == EV_UNDERRUN) ? m_sid[ch] : x.sid;
      return r;
   endfunction

   task automatic expect_event(input int ch, input tx_event_e kind, input tx_word_t x);
      rep_q.push_back(model_event(ch, kind, x));
      chan_q.push_back(ch);
   endtask

   task automatic model_play(input int ch, input tx_word_t x);
      samp_q[ch].push_back({1'b0, x.sample0});
      if (!x.odd) samp_q[ch].push_back({1'b0, x.sample1});
      m_exp[ch] = x.seqnum + 1'b1;
      m_sid[ch] = x.sid;
   endtask

   task automatic model_drain(input int ch, input tx_word_t x);
      m_exp[ch] = x.seqnum + 1'b1;
      m_sid[ch] = x.sid;
   endtask

   task automatic send_word(input int ch, input tx_word_t x);
      int n;
      n        = 0;
      in_valid = 1'b1;
      in_word  = x;
      in_chan  = 1'(ch);
      #1;
      while (!in_ready) begin
         saw_full = 1'b1;
         n++;
         if (n > TIMEOUT) abort_run("timeout waiting for in_ready");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic play_burst(input int ch, input int first, input int len);
      tx_word_t x;
      for (int i = 0; i < len; i++) begin
         x = make_word(ch, 12'(first + i), i == len - 1, 1'b0, 1'b0, '0);
         if (i == len - 1) expect_event(ch, EV_EOB_ACK, x);
         model_play(ch, x);
         send_word(ch, x);
      end
   endtask

   task automatic wait_samples(input string what);
      int n;
      n = 0;
      while (samp_q[0].size() != 0 || samp_q[1].size() != 0) begin
         n++;
         if (n > TIMEOUT) abort_run({"timeout waiting for samples: ", what});
         @(negedge clk);
      end
   endtask

   task automatic wait_reports(input string what);
      int n;
      n = 0;
      while (rep_q.size() != 0) begin
         n++;
         if (n > TIMEOUT) abort_run({"timeout waiting for status reports: ", what});
         @(negedge clk);
      end
      repeat (12) @(negedge clk);
   endtask

   task automatic write_policy(input int ch, input tx_policy_e p);
      set_stb  = 1'b1;
      set_addr = 8'h10 + 8'(ch);
      set_data = 32'(p);
      @(negedge clk);
      set_stb  = 1'b0;
      m_exp[ch] = '0;   // channel is idle so the clear lands right away
      repeat (3) @(negedge clk);
   endtask

   initial begin
      seed = 32'h3a427f18;
      for (int c = 0; c < 2; c++) begin
         m_exp[c] = '0;
         m_sid[c] = '0;
      end
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);

      // immediate burst with an odd packet in the middle
      w = make_word(0, 12'd0, 1'b0, 1'b0, 1'b0, '0);
      model_play(0, w);
      send_word(0, w);
      w = make_word(0, 12'd1, 1'b0, 1'b1, 1'b0, '0);
      model_play(0, w);
      send_word(0, w);
      w = make_word(0, 12'd2, 1'b1, 1'b0, 1'b0, '0);
      expect_event(0, EV_EOB_ACK, w);
      model_play(0, w);
      send_word(0, w);
      wait_samples("immediate burst");
      wait_reports("immediate burst");

      // timed start then a packet that is already late
      t_start = vita_time + 64'd40;
      w = make_word(0, 12'd3, 1'b1, 1'b0, 1'b1, t_start);
      expect_event(0, EV_EOB_ACK, w);
      model_play(0, w);
      send_word(0, w);
      t = 0;
      while (!run[0]) begin
         t++;
         if (t > TIMEOUT) abort_run("timeout waiting for run on the timed burst");
         @(negedge clk);
         #2;
      end
      if (vita_time <= t_start) abort_run("timed burst started before its send time");
      @(negedge clk);
      wait_samples("timed burst");
      wait_reports("timed burst");
      w = make_word(0, 12'd4, 1'b1, 1'b0, 1'b1, vita_time - 64'd10);
      expect_event(0, EV_TIME_ERROR, w);
      model_drain(0, w);
      send_word(0, w);
      wait_reports("late packet");

      // sequence errors at burst start and mid-burst
      w = make_word(0, 12'd9, 1'b1, 1'b0, 1'b0, '0);
      expect_event(0, EV_SEQ_ERROR, w);
      model_drain(0, w);
      send_word(0, w);
      wait_reports("start sequence error");
      w = make_word(0, 12'd10, 1'b0, 1'b0, 1'b0, '0);
      model_play(0, w);
      send_word(0, w);
      w = make_word(0, 12'd20, 1'b0, 1'b0, 1'b0, '0);
      expect_event(0, EV_SEQ_ERROR_MIDBURST, w);
      samp_q[0].push_back({1'b1, 32'h0});
      model_drain(0, w);
      send_word(0, w);
      w = make_word(0, 12'd21, 1'b1, 1'b0, 1'b0, '0);
      expect_event(0, EV_EOB_ACK, w);
      model_play(0, w);
      send_word(0, w);
      wait_samples("mid-burst sequence error");
      wait_reports("mid-burst sequence error");

      // burst policy drains until an eob packet
      write_policy(0, POL_NEXT_BURST);
      w = make_word(0, 12'd7, 1'b0, 1'b0, 1'b0, '0);
      expect_event(0, EV_SEQ_ERROR, w);
      model_drain(0, w);
      send_word(0, w);
      w = make_word(0, 12'd8, 1'b0, 1'b0, 1'b0, '0);
      model_drain(0, w);
      send_word(0, w);
      w = make_word(0, 12'd9, 1'b1, 1'b0, 1'b0, '0);
      model_drain(0, w);
      send_word(0, w);
      play_burst(0, 10, 1);
      wait_samples("burst policy recovery");
      wait_reports("burst policy recovery");

      // channel 1 runs dry mid-burst
      for (int i = 0; i < 3; i++) begin
         w = make_word(1, 12'(i), 1'b0, 1'b0, 1'b0, '0);
         model_play(1, w);
         send_word(1, w);
      end
      expect_event(1, EV_UNDERRUN, w);
      samp_q[1].push_back({1'b1, 32'h0});
      wait_samples("underrun");
      wait_reports("underrun");
      w = make_word(1, 12'd3, 1'b1, 1'b0, 1'b0, '0);
      model_drain(1, w);
      send_word(1, w);
      repeat (10) @(negedge clk);

      // both channels with the status output stalled
      status_ready = 1'b0;
      play_burst(0, 11, 6);
      play_burst(1, 4, 6);
      wait_samples("stalled status bursts");
      repeat (20) @(negedge clk);
      status_ready = 1'b1;
      wait_reports("stalled status bursts");
      repeat (20) @(negedge clk);

      if (!saw_full) begin
         abort_run("in_ready never dropped with credits spent");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tx_subsystem.f ====
common/tx_types_pkg.sv
common/tx_cfg_pkg.sv
common/tx_status_if.sv
tx_channel/tx_sample_fifo.sv
tx_channel/tx_channel.sv
source/tx_distributor.sv
source/tx_status_arbiter.sv
source/tx_subsystem.sv
verif/tb_tx_subsystem.sv

// ==== Bender.yml ====
package:
  name: tx_subsystem

sources:
  - common/tx_types_pkg.sv
  - common/tx_cfg_pkg.sv
  - common/tx_status_if.sv
  - tx_channel/tx_sample_fifo.sv
  - tx_channel/tx_channel.sv
  - source/tx_distributor.sv
  - source/tx_status_arbiter.sv
  - source/tx_subsystem.sv
  - target: test
    files:
      - verif/tb_tx_subsystem.sv
